/* hw/can_host_pkg.sv */
package can_host_pkg;

  typedef logic [4:0]  addr_t;  // Controller register address
  typedef logic [15:0] word_t;  // Controller register word
  typedef logic [75:0] msg_t;   // Bit 75 unused, 74:64 id, 63:0 bytes 0..7
  typedef logic [2:0]  step_t;  // Sequence step index

  typedef enum logic [1:0] {
    CMD_NONE  = 2'b00,
    CMD_INIT  = 2'b01,
    CMD_READ  = 2'b10,
    CMD_WRITE = 2'b11
  } cmd_e;

  // Transmit side registers
  localparam addr_t ADDR_TX_ID   = 5'b01100;
  localparam addr_t ADDR_TX_D12  = 5'b01010;
  localparam addr_t ADDR_TX_D34  = 5'b01001;
  localparam addr_t ADDR_TX_D56  = 5'b01000;
  localparam addr_t ADDR_TX_D78  = 5'b00111;
  localparam addr_t ADDR_GENERAL = 5'b01110;
  localparam addr_t ADDR_IRQ     = 5'b10010;
  localparam addr_t ADDR_TX_CTRL = 5'b01101;

  // Receive side registers
  localparam addr_t ADDR_RX_ID  = 5'b00101;
  localparam addr_t ADDR_RX_D12 = 5'b00100;
  localparam addr_t ADDR_RX_D34 = 5'b00011;
  localparam addr_t ADDR_RX_D56 = 5'b00010;
  localparam addr_t ADDR_RX_D78 = 5'b00001;

  // Configuration registers only touched during init
  localparam addr_t ADDR_BIT_TIMING = 5'b10000;
  localparam addr_t ADDR_PRESCALER  = 5'b10001;
  localparam addr_t ADDR_IRQ_MASK   = 5'b10011;

  localparam word_t GEN_DATA  = 16'h009C;  // Controller enabled, auto retransmit
  localparam word_t IRQ_RESET = 16'h8070;  // Clear pending interrupts
  localparam word_t TX_CTRL   = 16'h8008;  // Request transmission

  localparam int INIT_LEN = 4;
  localparam int TX_LEN   = 8;
  localparam int RX_LEN   = 5;

  localparam step_t INIT_LAST = step_t'(INIT_LEN - 1);
  localparam step_t TX_LAST   = step_t'(TX_LEN - 1);
  localparam step_t RX_LAST   = step_t'(RX_LEN - 1);

  localparam addr_t INIT_ADDR [INIT_LEN] = '{
    ADDR_BIT_TIMING, ADDR_PRESCALER, ADDR_GENERAL, ADDR_IRQ_MASK
  };
  localparam word_t INIT_DATA [INIT_LEN] = '{
    16'h3A47, 16'h0004, 16'h0098, 16'h0070
  };

  localparam addr_t TX_SEQ [TX_LEN] = '{
    ADDR_TX_ID, ADDR_TX_D12, ADDR_TX_D34, ADDR_TX_D56,
    ADDR_TX_D78, ADDR_GENERAL, ADDR_IRQ, ADDR_TX_CTRL
  };
  localparam addr_t RX_SEQ [RX_LEN] = '{
    ADDR_RX_ID, ADDR_RX_D12, ADDR_RX_D34, ADDR_RX_D56, ADDR_RX_D78
  };

endpackage

/* hw/can_reg_bus_if.sv */
`timescale 1ns/1ps

// One controller register access per cycle, issued by the sequencer
interface can_reg_bus_if;

  can_host_pkg::cmd_e  cmd;        // Access kind
  can_host_pkg::addr_t addr;       // Target register
  can_host_pkg::word_t init_data;  // Write data for init accesses
  logic                last;       // Final access of a sequence

  modport master (
    output cmd,
    output addr,
    output init_data,
    output last
  );

  modport slave (
    input cmd,
    input addr,
    input init_data,
    input last
  );

endinterface

/* hw/can_host_sequencer.sv */
`timescale 1ns/1ps

module can_host_sequencer (
  input  logic          clock,
  input  logic          arst_n,
  input  logic          tx_start,
  input  logic          rx_start,
  can_reg_bus_if.master bus,
  output logic          init_done,
  output logic          busy,
  output logic          tx_done
);

  typedef enum logic [1:0] {
    ST_INIT,
    ST_IDLE,
    ST_TX,
    ST_RX
  } state_t;

  state_t                state;
  can_host_pkg::step_t   step;  // Next table entry to issue

  // Only real sequences count as busy, init is covered by init_done
  assign busy = (state == ST_TX) || (state == ST_RX);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state         <= ST_INIT;
      step          <= '0;
      init_done     <= 1'b0;
      tx_done       <= 1'b0;
      bus.cmd       <= can_host_pkg::CMD_NONE;
      bus.addr      <= '0;
      bus.init_data <= '0;
      bus.last      <= 1'b0;
    end else begin
      // Default to an idle bus, strobes last one cycle
      bus.cmd  <= can_host_pkg::CMD_NONE;
      bus.last <= 1'b0;
      tx_done  <= 1'b0;

      case (state)
        ST_INIT: begin
          if (bus.last) begin
            state     <= ST_IDLE;  // Last init write just went out
            init_done <= 1'b1;
          end else begin
            bus.cmd       <= can_host_pkg::CMD_INIT;
            bus.addr      <= can_host_pkg::INIT_ADDR[step[1:0]];
            bus.init_data <= can_host_pkg::INIT_DATA[step[1:0]];
            bus.last      <= (step == can_host_pkg::INIT_LAST);
            step          <= step + 3'd1;
          end
        end

        ST_IDLE: begin
          if (tx_start) begin  // Transmit wins over a same-cycle receive
            state    <= ST_TX;
            bus.cmd  <= can_host_pkg::CMD_WRITE;
            bus.addr <= can_host_pkg::TX_SEQ[0];
            step     <= 3'd1;
          end else if (rx_start) begin
            state    <= ST_RX;
            bus.cmd  <= can_host_pkg::CMD_READ;
            bus.addr <= can_host_pkg::RX_SEQ[0];
            step     <= 3'd1;
          end
        end

        ST_TX: begin
          if (bus.last) begin
            state <= ST_IDLE;
          end else begin
            bus.cmd  <= can_host_pkg::CMD_WRITE;
            bus.addr <= can_host_pkg::TX_SEQ[step];
            bus.last <= (step == can_host_pkg::TX_LAST);
            tx_done  <= (step == can_host_pkg::TX_LAST);  // With the control write
            step     <= step + 3'd1;
          end
        end

        ST_RX: begin
          if (bus.last) begin
            state <= ST_IDLE;
          end else begin
            bus.cmd  <= can_host_pkg::CMD_READ;
            bus.addr <= can_host_pkg::RX_SEQ[step];
            bus.last <= (step == can_host_pkg::RX_LAST);
            step     <= step + 3'd1;
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* hw/can_reg_formatter.sv */
`timescale 1ns/1ps

module can_reg_formatter (
  input  logic                clock,
  input  logic                arst_n,
  can_reg_bus_if.slave        bus,
  input  can_host_pkg::msg_t  tx_msg,
  input  can_host_pkg::addr_t tx_buffer,
  input  can_host_pkg::addr_t rx_buffer,
  output can_host_pkg::addr_t can_addr,
  output logic                can_we,
  output logic                can_re,
  output can_host_pkg::word_t write_can,
  output can_host_pkg::addr_t can_tra_select,
  output can_host_pkg::addr_t can_rec_select
);

  assign can_addr = bus.addr;
  assign can_we   = (bus.cmd == can_host_pkg::CMD_INIT) ||
                    (bus.cmd == can_host_pkg::CMD_WRITE);
  assign can_re   = (bus.cmd == can_host_pkg::CMD_READ);

  // Spread the message over the transmit registers
  always_comb begin
    write_can = '0;
    case (bus.cmd)
      can_host_pkg::CMD_INIT: begin
        write_can = bus.init_data;
      end
      can_host_pkg::CMD_WRITE: begin
        case (bus.addr)
          can_host_pkg::ADDR_TX_ID: begin
            write_can = {tx_msg[74:64], 5'b00000};  // Identifier left aligned
          end
          can_host_pkg::ADDR_TX_D12: begin
            write_can = {tx_msg[63:56], tx_msg[47:40]};  // Bytes 0 and 2
          end
          can_host_pkg::ADDR_TX_D34: begin
            write_can = {tx_msg[55:48], tx_msg[39:32]};  // Bytes 1 and 3
          end
          can_host_pkg::ADDR_TX_D56: begin
            write_can = {tx_msg[7:0], tx_msg[15:8]};  // Bytes 7 and 6
          end
          can_host_pkg::ADDR_TX_D78: begin
            write_can = {tx_msg[23:16], tx_msg[31:24]};  // Bytes 5 and 4
          end
          can_host_pkg::ADDR_GENERAL: write_can = can_host_pkg::GEN_DATA;
          can_host_pkg::ADDR_IRQ:     write_can = can_host_pkg::IRQ_RESET;
          can_host_pkg::ADDR_TX_CTRL: write_can = can_host_pkg::TX_CTRL;
          default:                    write_can = '0;
        endcase
      end
      default: begin
        write_can = '0;
      end
    endcase
  end

  // Buffer selects follow the last access of their kind
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      can_tra_select <= '0;
      can_rec_select <= '0;
    end else begin
      case (bus.cmd)
        can_host_pkg::CMD_INIT,
        can_host_pkg::CMD_WRITE: can_tra_select <= tx_buffer;
        can_host_pkg::CMD_READ:  can_rec_select <= rx_buffer;
        default: begin
          can_tra_select <= can_tra_select;
          can_rec_select <= can_rec_select;
        end
      endcase
    end
  end

endmodule

/* hw/can_rx_assembler.sv */
`timescale 1ns/1ps

module can_rx_assembler (
  input  logic                clock,
  input  logic                arst_n,
  can_reg_bus_if.slave        bus,
  input  can_host_pkg::word_t read_can,
  output can_host_pkg::msg_t  rx_msg,
  output logic                rx_valid
);

  logic rd_access;

  assign rd_access = (bus.cmd == can_host_pkg::CMD_READ);

  // Same field layout as the transmit side, read back into place
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_msg <= '0;  // Keeps the unused top bit defined
    end else if (rd_access) begin
      case (bus.addr)
        can_host_pkg::ADDR_RX_ID: begin
          rx_msg[74:64] <= read_can[15:5];  // Low five bits carry no id
        end
        can_host_pkg::ADDR_RX_D12: begin
          rx_msg[63:56] <= read_can[15:8];
          rx_msg[47:40] <= read_can[7:0];
        end
        can_host_pkg::ADDR_RX_D34: begin
          rx_msg[55:48] <= read_can[15:8];
          rx_msg[39:32] <= read_can[7:0];
        end
        can_host_pkg::ADDR_RX_D56: begin
          rx_msg[7:0]  <= read_can[15:8];  // Byte 7 sits high here
          rx_msg[15:8] <= read_can[7:0];
        end
        can_host_pkg::ADDR_RX_D78: begin
          rx_msg[23:16] <= read_can[15:8];
          rx_msg[31:24] <= read_can[7:0];
        end
        default: begin
          rx_msg <= rx_msg;
        end
      endcase
    end
  end

  // One cycle after the final read
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= rd_access && bus.last;
    end
  end

endmodule

/* hw/can_host_top.sv */
`timescale 1ns/1ps

module can_host_top (
  input  logic                clock,
  input  logic                arst_n,
  input  logic                tx_start,
  input  can_host_pkg::msg_t  tx_msg,
  input  can_host_pkg::addr_t tx_buffer,
  input  logic                rx_start,
  input  can_host_pkg::addr_t rx_buffer,
  input  can_host_pkg::word_t read_can,
  output can_host_pkg::addr_t can_addr,
  output logic                can_we,
  output logic                can_re,
  output can_host_pkg::word_t write_can,
  output can_host_pkg::addr_t can_tra_select,
  output can_host_pkg::addr_t can_rec_select,
  output logic                init_done,
  output logic                busy,
  output logic                tx_done,
  output can_host_pkg::msg_t  rx_msg,
  output logic                rx_valid
);

  can_reg_bus_if bus_i ();  // Sequencer to formatter and assembler

  can_host_sequencer can_host_sequencer_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .tx_start  (tx_start),
    .rx_start  (rx_start),
    .bus       (bus_i.master),
    .init_done (init_done),
    .busy      (busy),
    .tx_done   (tx_done)
  );

  can_reg_formatter can_reg_formatter_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .bus            (bus_i.slave),
    .tx_msg         (tx_msg),
    .tx_buffer      (tx_buffer),
    .rx_buffer      (rx_buffer),
    .can_addr       (can_addr),
    .can_we         (can_we),
    .can_re         (can_re),
    .write_can      (write_can),
    .can_tra_select (can_tra_select),
    .can_rec_select (can_rec_select)
  );

  can_rx_assembler can_rx_assembler_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .bus      (bus_i.slave),
    .read_can (read_can),
    .rx_msg   (rx_msg),
    .rx_valid (rx_valid)
  );

endmodule

/* tb/can_host_assert.sv */
`timescale 1ns/1ps

module can_host_assert (
  input logic       clock,
  input logic       arst_n,
  input logic       can_we,
  input logic       can_re,
  input logic       tx_done,
  input logic       rx_valid,
  input logic [4:0] can_addr
);

  // Never a read and a write in one access
  assert property (@(posedge clock) disable iff (!arst_n) !(can_we && can_re))
    else $error("can_we and can_re high together");

  // Done comes with the transmit control write
  assert property (@(posedge clock) disable iff (!arst_n)
    tx_done |-> (can_we && can_addr == 5'b01101))
    else $error("tx_done without the control write");

  assert property (@(posedge clock) disable iff (!arst_n) rx_valid |=> !rx_valid)
    else $error("rx_valid longer than one cycle");

endmodule

bind can_host_top can_host_assert can_host_assert_i (.*);

/* tb/tb_can_host.sv */
`timescale 1ns/1ps

module tb_can_host;

  logic        clock;
  logic        arst_n;
  logic        tx_start;
  logic        rx_start;
  logic [75:0] tx_msg;
  logic [4:0]  tx_buffer;
  logic [4:0]  rx_buffer;
  logic [15:0] read_can;
  logic [4:0]  can_addr;
  logic        can_we;
  logic        can_re;
  logic [15:0] write_can;
  logic [4:0]  can_tra_select;
  logic [4:0]  can_rec_select;
  logic        init_done;
  logic        busy;
  logic        tx_done;
  logic [75:0] rx_msg;
  logic        rx_valid;

  logic [15:0] rx_words [32];   // Preloaded receive registers
  logic [15:0] reg_model [32];  // Captured writes
  logic [4:0]  exp_addr [8];
  logic [15:0] exp_data [8];
  logic [4:0]  last_tx_buf;
  logic [4:0]  last_rx_buf;
  int          cyc;
  int          seed;
  int          init_rise;
  int          log_cyc [$];
  logic [4:0]  log_addr [$];
  logic [15:0] log_data [$];
  logic        log_we [$];
  logic        log_txd [$];
  int          rxv_cyc [$];
  logic [75:0] rxv_msg [$];
  int          busy_cyc [$];

  can_host_top can_host_top_i (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;
  always @(posedge clock) cyc <= cyc + 1;

  // Controller register file model
  assign read_can = can_re ? rx_words[can_addr] : 16'h0000;
  always @(posedge clock) if (can_we) reg_model[can_addr] <= write_can;

  // Log every access of the cycle that just ended
  always @(posedge clock) begin
    if (arst_n) begin
      if (can_we || can_re) begin
        log_cyc.push_back(cyc);
        log_addr.push_back(can_addr);
        log_data.push_back(write_can);
        log_we.push_back(can_we);
        log_txd.push_back(tx_done);
      end
      if (rx_valid) begin
        rxv_cyc.push_back(cyc);
        rxv_msg.push_back(rx_msg);
      end
      if (busy) begin
        busy_cyc.push_back(cyc);
      end
      if (init_done && init_rise < 0) init_rise = cyc;
    end
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_eq(input string name, input logic [75:0] got, input logic [75:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      fail_now("value mismatch");
    end
  endtask

  // which: 0 init_done, 1 tx_done, 2 rx_valid
  task automatic wait_for(input int which, input string what);
    int   n;
    logic hit;
    n = 0;
    hit = 1'b0;
    while (!hit) begin
      @(posedge clock);
      hit = (which == 0) ? init_done : (which == 1) ? tx_done : rx_valid;
      n++;
      assert (n < 100) else fail_now({"timeout waiting for ", what});
    end
    repeat (10) @(posedge clock);  // Let dropped strobes show up if any
  endtask

  // Accesses after cycle s must match exp_addr/exp_data one per cycle
  task automatic check_seq(input int s, input int len, input logic we, input logic txd_last);
    int n;
    n = 0;
    foreach (log_cyc[k]) begin
      if (log_cyc[k] > s && log_cyc[k] <= s + 16) begin
        assert (n < len) else fail_now("extra register access after the sequence");
        check_eq("access cycle", 76'(log_cyc[k]), 76'(s + 1 + n));
        check_eq("can_we", 76'(log_we[k]), 76'(we));
        check_eq("can_addr", 76'(log_addr[k]), 76'(exp_addr[n]));
        if (we) begin
          check_eq("write_can", 76'(log_data[k]), 76'(exp_data[n]));
          check_eq("tx_done", 76'(log_txd[k]), 76'(txd_last && n == len - 1));
        end
        n++;
      end
    end
    check_eq("access count", 76'(n), 76'(len));
  endtask

  // Busy covers cycles s+1 to s+len and falls right after
  task automatic check_busy(input int s, input int len);
    int n;
    n = 0;
    foreach (busy_cyc[k]) begin
      if (busy_cyc[k] > s && busy_cyc[k] <= s + 16) begin
        check_eq("busy cycle", 76'(busy_cyc[k]), 76'(s + 1 + n));
        n++;
      end
    end
    check_eq("busy length", 76'(n), 76'(len));
  endtask

  function automatic logic [7:0] msg_byte(input logic [75:0] msg, input int k);
    return msg[63 - 8 * k -: 8];  // Byte 0 is the highest
  endfunction

  task automatic do_tx(input logic [75:0] msg, input logic [4:0] bufv, input logic both);
    int s;
    int nv;
    @(posedge clock);
    s = cyc + 1;
    tx_msg <= msg;
    tx_buffer <= bufv;
    rx_buffer <= 5'($random(seed));  // Must not reach can_rec_select
    tx_start <= 1'b1;
    rx_start <= both;
    @(posedge clock);
    tx_start <= 1'b0;
    rx_start <= 1'b0;
    @(posedge clock);
    tx_start <= 1'b1;  // While busy, both dropped
    rx_start <= 1'b1;
    @(posedge clock);
    tx_start <= 1'b0;
    rx_start <= 1'b0;
    wait_for(1, "tx_done");
    exp_addr = '{5'b01100, 5'b01010, 5'b01001, 5'b01000, 5'b00111, 5'b01110, 5'b10010,
                 5'b01101};
    exp_data[0] = {msg[74:64], 5'b00000};
    exp_data[1] = {msg_byte(msg, 0), msg_byte(msg, 2)};
    exp_data[2] = {msg_byte(msg, 1), msg_byte(msg, 3)};
    exp_data[3] = {msg_byte(msg, 7), msg_byte(msg, 6)};
    exp_data[4] = {msg_byte(msg, 5), msg_byte(msg, 4)};
    exp_data[5] = 16'h009C;
    exp_data[6] = 16'h8070;
    exp_data[7] = 16'h8008;
    check_seq(s, 8, 1'b1, 1'b1);
    check_busy(s, 8);
    nv = 0;
    foreach (rxv_cyc[k]) if (rxv_cyc[k] > s && rxv_cyc[k] <= s + 16) nv++;
    check_eq("rx_valid count", 76'(nv), 76'(0));
    check_eq("can_tra_select", 76'(can_tra_select), 76'(bufv));
    check_eq("can_rec_select", 76'(can_rec_select), 76'(last_rx_buf));
    check_eq("model tx id", 76'(reg_model[5'b01100]), 76'(exp_data[0]));
    last_tx_buf = bufv;
  endtask

  task automatic do_rx(input logic [4:0] bufv);
    int          s;
    int          nv;
    logic [75:0] exp_msg;
    rx_words[5'b00101] = 16'($random(seed));
    rx_words[5'b00100] = 16'($random(seed));
    rx_words[5'b00011] = 16'($random(seed));
    rx_words[5'b00010] = 16'($random(seed));
    rx_words[5'b00001] = 16'($random(seed));
    exp_msg = {1'b0, rx_words[5'b00101][15:5],
               rx_words[5'b00100][15:8], rx_words[5'b00011][15:8],
               rx_words[5'b00100][7:0], rx_words[5'b00011][7:0],
               rx_words[5'b00001][7:0], rx_words[5'b00001][15:8],
               rx_words[5'b00010][7:0], rx_words[5'b00010][15:8]};
    @(posedge clock);
    s = cyc + 1;
    rx_buffer <= bufv;
    tx_buffer <= 5'($random(seed));  // Must not reach can_tra_select
    rx_start <= 1'b1;
    @(posedge clock);
    rx_start <= 1'b0;
    @(posedge clock);
    tx_start <= 1'b1;
    rx_start <= 1'b1;
    @(posedge clock);
    tx_start <= 1'b0;
    rx_start <= 1'b0;
    wait_for(2, "rx_valid");
    exp_addr = '{5'b00101, 5'b00100, 5'b00011, 5'b00010, 5'b00001, 5'b0, 5'b0, 5'b0};
    check_seq(s, 5, 1'b0, 1'b0);
    check_busy(s, 5);
    nv = 0;
    foreach (rxv_cyc[k]) begin
      if (rxv_cyc[k] > s && rxv_cyc[k] <= s + 16) begin
        check_eq("rx_valid cycle", 76'(rxv_cyc[k]), 76'(s + 6));
        check_eq("rx_msg", rxv_msg[k], exp_msg);
        nv++;
      end
    end
    check_eq("rx_valid count", 76'(nv), 76'(1));
    check_eq("can_rec_select", 76'(can_rec_select), 76'(bufv));
    check_eq("can_tra_select", 76'(can_tra_select), 76'(last_tx_buf));
    last_rx_buf = bufv;
  endtask

  initial begin
    int s;
    seed = 32'h9f63;
    cyc = 0;
    init_rise = -1;
    arst_n = 1'b0;
    tx_start = 1'b0;
    rx_start = 1'b0;
    tx_msg = '0;
    tx_buffer = '0;
    rx_buffer = '0;
    last_tx_buf = '0;
    last_rx_buf = '0;
    foreach (rx_words[i]) rx_words[i] = 16'h0000;
    repeat (8) @(posedge clock);
    s = cyc + 1;
    arst_n <= 1'b1;
    wait_for(0, "init_done");
    for (int i = 0; i < 4; i++) begin
      exp_addr[i] = can_host_pkg::INIT_ADDR[i];
      exp_data[i] = can_host_pkg::INIT_DATA[i];
    end
    check_seq(s, 4, 1'b1, 1'b0);
    check_eq("init_done rise", 76'(init_rise), 76'(s + 5));
    for (int r = 0; r < 4; r++) begin
      do_tx(76'({$random(seed), $random(seed), $random(seed)}), 5'($random(seed)), 1'b0);
      do_rx(5'($random(seed)));
    end
    do_tx(76'({$random(seed), $random(seed), $random(seed)}), 5'($random(seed)), 1'b1);
    $display("sim passed");
    $finish;
  end

endmodule

/* src.f */
hw/can_host_pkg.sv
hw/can_reg_bus_if.sv
hw/can_host_sequencer.sv
hw/can_reg_formatter.sv
hw/can_rx_assembler.sv
hw/can_host_top.sv
tb/can_host_assert.sv
tb/tb_can_host.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CAN host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_can_host -f src.f -o sim_can_host
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_can_host > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
